// ==== include/board_config.svh ====
`default_nettype none

`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

//----------------------------------------------------------------------
// HEX display mode
//----------------------------------------------------------------------

// 1'b1 holds each scanned digit in sticky flops (bright, static)
// 1'b0 drives HEX only while its digit is selected, which mimics a
// dynamic display on static hardware and makes the segments dim
`define SEG7_STICKY_FLOPS 1'b1

`endif

`default_nettype wire

// ==== rtl/board_pkg.sv ====
`default_nettype none

package board_pkg;

    localparam int w_digit = 4;   // HEX displays on the board
    localparam int w_mic   = 24;  // I2S sample width
    localparam int w_led   = 14;  // Red LEDs minus dp ones plus green

    typedef logic [3:0] hex_nibble_t;

    // Segment pattern {a,b,c,d,e,f,g}, active high
    function automatic logic [6:0] seg_from_hex(input hex_nibble_t h);
        case (h)
            4'h0: return 7'b1111110;
            4'h1: return 7'b0110000;
            4'h2: return 7'b1101101;
            4'h3: return 7'b1111001;
            4'h4: return 7'b0110011;
            4'h5: return 7'b1011011;
            4'h6: return 7'b1011111;
            4'h7: return 7'b1110000;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1111011;
            4'ha: return 7'b1110111;
            4'hb: return 7'b0011111;
            4'hc: return 7'b1001110;
            4'hd: return 7'b0111101;
            4'he: return 7'b1001111;
            default: return 7'b1000111;  // F
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== rtl/display_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface display_if import board_pkg::*; ();

    hex_nibble_t [w_digit-1:0] digits;     // Nibble per digit, [0] is rightmost
    logic        [w_digit-1:0] dots;       // Decimal point per digit
    logic        [w_digit-1:0] blank;      // Digit switched off
    logic                      scan_step;  // Advance scanner by one digit

    // Lab side
    modport source (output digits, output dots, output blank, output scan_step);

    // Scanner side
    modport sink (input digits, input dots, input blank, input scan_step);

endinterface

`default_nettype wire

// ==== rtl/slow_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module slow_clk_gen
#(
    parameter int fast_clk_mhz = 50,
    parameter int slow_clk_hz  = 1
)
(
    input  wire  clk,
    input  wire  rst,
    output logic slow_clk  // Plain level, not a clock net
);

    localparam int half_period = fast_clk_mhz * 1_000_000 / (2 * slow_clk_hz);
    localparam int w_cnt       = half_period > 1 ? $clog2(half_period) : 1;

    logic [w_cnt-1:0] cnt;  // Cycles left in this half period

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt      <= w_cnt'(half_period - 1);
            slow_clk <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt      <= w_cnt'(half_period - 1);  // Reload
            slow_clk <= ~slow_clk;                // Half period done
        end
        else
        begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/i2s_mic_receiver.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2s_mic_receiver import board_pkg::*;
#(
    parameter int mic_sck_div = 8  // clk cycles per sck half period
)
(
    input  wire              clk,
    input  wire              rst,
    output logic             sck,
    output logic             ws,           // Low selects left channel
    input  wire              sd,
    output logic [w_mic-1:0] value,        // Last complete sample
    output logic             value_valid   // One cycle per new sample
);

    localparam int w_div = mic_sck_div > 1 ? $clog2(mic_sck_div) : 1;

    logic [w_div-1:0] div_cnt;      // sck prescaler
    logic             tick;         // sck toggles this cycle
    logic             sck_rise;
    logic             sck_fall;
    logic [5:0]       slot;         // Bit slot within the 64-sck frame
    logic [w_mic-1:0] shift_reg;    // Sample being received
    logic             sample;       // Take sd now
    logic             last_sample;  // Final bit of the word
    logic             frame_done;

    //------------------------------------------------------------------
    // Bit clock and word select
    //------------------------------------------------------------------

    assign tick     = div_cnt == w_div'(mic_sck_div - 1);
    assign sck_rise = tick & ~sck;
    assign sck_fall = tick & sck;
    assign ws       = slot[5];  // 32 slots per channel

    // Slot 0 is the one-bit I2S delay, data sits in slots 1..24
    assign sample      = sck_rise & ~ws & (slot >= 6'd1) & (slot <= 6'(w_mic));
    assign last_sample = sample & (slot == 6'(w_mic));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt     <= '0;
            sck         <= 1'b0;
            slot        <= '0;
            frame_done  <= 1'b0;
            value       <= '0;
            value_valid <= 1'b0;
        end
        else
        begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;

            if (tick)
                sck <= ~sck;

            if (sck_fall)
                slot <= slot + 1'b1;  // ws moves on falling sck

            //----------------------------------------------------------
            // Commit the whole word at once
            //----------------------------------------------------------

            frame_done  <= last_sample;
            value_valid <= frame_done;

            if (frame_done)
                value <= shift_reg;
        end
    end

    // MSB arrives first
    always_ff @(posedge clk)
    begin
        if (sample)
            shift_reg <= {shift_reg[w_mic-2:0], sd};
    end

endmodule

`default_nettype wire

// ==== rtl/seg7_scanner.sv ====
`timescale 1ns/10ps
`default_nettype none

module seg7_scanner import board_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    display_if.sink            disp,
    output logic [7:0]         abcdefgh,  // Bit 7 is a, bit 0 is dp
    output logic [w_digit-1:0] digit      // One-hot select
);

    logic [w_digit-1:0] next_digit;
    logic [7:0]         next_seg;

    //------------------------------------------------------------------
    // Pattern of the digit that comes next
    //------------------------------------------------------------------

    always_comb
    begin
        next_digit = {digit[w_digit-2:0], digit[w_digit-1]};  // Rotate left
        next_seg   = '0;                                      // Blank default

        for (int i = 0; i < w_digit; i++)
        begin
            if (next_digit[i] && !disp.blank[i])
                next_seg = {seg_from_hex(disp.digits[i]), disp.dots[i]};
        end
    end

    // Select and segments move together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit    <= w_digit'(1);
            abcdefgh <= '0;
        end
        else if (disp.scan_step)
        begin
            digit    <= next_digit;
            abcdefgh <= next_seg;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/seg7_static_latch.sv ====
`include "board_config.svh"

`timescale 1ns/10ps
`default_nettype none

module seg7_static_latch import board_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire  [7:0]         abcdefgh,
    input  wire  [w_digit-1:0] digit,
    output logic [6:0]         hex0,  // Active low, bit 0 is a
    output logic [6:0]         hex1,
    output logic [6:0]         hex2,
    output logic [6:0]         hex3,
    output logic [w_digit-1:0] dp     // Active high on red LEDs
);

    localparam bit sticky_flops = `SEG7_STICKY_FLOPS;

    logic [7:0] hgfedcba;          // Board bit order
    logic [6:0] hex_q [w_digit];   // Per-digit HEX value

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = abcdefgh[7 - i];
    end

    //------------------------------------------------------------------
    // HEX drive
    //------------------------------------------------------------------

    if (sticky_flops)
    begin : g_sticky
        always_ff @(posedge clk or posedge rst)
        begin
            if (rst)
            begin
                for (int i = 0; i < w_digit; i++)
                    hex_q[i] <= '1;  // All segments off
                dp <= '0;
            end
            else
            begin
                for (int i = 0; i < w_digit; i++)
                begin
                    if (digit[i])
                    begin
                        hex_q[i] <= ~hgfedcba[6:0];  // Only the selected digit loads
                        dp[i]    <= hgfedcba[7];
                    end
                end
            end
        end
    end
    else
    begin : g_dynamic
        always_comb
        begin
            for (int i = 0; i < w_digit; i++)
            begin
                hex_q[i] = digit[i] ? ~hgfedcba[6:0] : '1;
                dp[i]    = digit[i] & hgfedcba[7];
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

endmodule

`default_nettype wire

// ==== rtl/lab_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lab_top import board_pkg::*;
#(
    parameter int scan_div = 1024  // clk cycles per digit step
)
(
    input  wire              clk,
    input  wire              rst,
    input  wire              slow_clk,
    input  wire  [3:0]       key,        // [0] mic view, [1] clear
    input  wire  [8:0]       sw,         // [0] pause, [4:1] dots, [8:5] blank
    input  wire  [w_mic-1:0] mic_value,
    input  wire              mic_valid,
    output logic [w_led-1:0] led,
    display_if.source        disp
);

    localparam int w_count = 4 * w_digit;  // One nibble per digit
    localparam int w_scan  = scan_div > 1 ? $clog2(scan_div) : 1;

    logic               slow_clk_d;  // For edge detect
    logic               slow_rise;
    logic [w_count-1:0] count;       // Event counter
    logic [w_count-1:0] mic_hold;    // Upper bits of last sample
    logic [w_count-1:0] shown;
    logic [w_scan-1:0]  scan_cnt;
    logic               scan_step_q;

    //------------------------------------------------------------------
    // Paced counter
    //------------------------------------------------------------------

    assign slow_rise = slow_clk & ~slow_clk_d;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            slow_clk_d  <= 1'b0;
            count       <= '0;
            scan_cnt    <= '0;
            scan_step_q <= 1'b0;
        end
        else
        begin
            slow_clk_d <= slow_clk;

            if (key[1])
                count <= '0;                   // Clear wins over pause
            else if (slow_rise && !sw[0])
                count <= count + 1'b1;

            // Scan prescaler
            scan_step_q <= scan_cnt == w_scan'(scan_div - 1);
            scan_cnt    <= (scan_cnt == w_scan'(scan_div - 1)) ? '0 : scan_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (mic_valid)
            mic_hold <= mic_value[w_mic-1 -: w_count];
    end

    //------------------------------------------------------------------
    // Display request
    //------------------------------------------------------------------

    assign shown          = key[0] ? mic_hold : count;
    assign disp.digits    = shown;
    assign disp.dots      = sw[4:1];
    assign disp.blank     = sw[8:5];
    assign disp.scan_step = scan_step_q;

    assign led = count[w_led-1:0];

endmodule

`default_nettype wire

// ==== rtl/board_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_top import board_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int slow_clk_hz = 1,
    parameter int mic_sck_div = 8,
    parameter int scan_div    = 1024
)
(
    input  wire                clk,
    input  wire                rst,
    input  wire  [3:0]         key,      // Active high
    input  wire  [8:0]         sw,
    input  wire                mic_sd,
    output logic [w_led-1:0]   led,
    output logic [6:0]         hex0,
    output logic [6:0]         hex1,
    output logic [6:0]         hex2,
    output logic [6:0]         hex3,
    output logic [w_digit-1:0] dp,       // Last four red LEDs
    output logic               mic_sck,
    output logic               mic_ws    // L/R pin strapped on the board
);

    logic               slow_clk;
    logic [w_mic-1:0]   mic_value;
    logic               mic_valid;
    logic [7:0]         abcdefgh;
    logic [w_digit-1:0] digit;

    display_if disp ();  // Lab to scanner

    //------------------------------------------------------------------
    // Sources
    //------------------------------------------------------------------

    slow_clk_gen #(.fast_clk_mhz(clk_mhz), .slow_clk_hz(slow_clk_hz)) slow_clk_gen_inst
    (
        .clk      (clk),
        .rst      (rst),
        .slow_clk (slow_clk)
    );

    i2s_mic_receiver #(.mic_sck_div(mic_sck_div)) i2s_mic_receiver_inst
    (
        .clk         (clk),
        .rst         (rst),
        .sck         (mic_sck),
        .ws          (mic_ws),
        .sd          (mic_sd),
        .value       (mic_value),
        .value_valid (mic_valid)
    );

    //------------------------------------------------------------------
    // Lab and display path
    //------------------------------------------------------------------

    lab_top #(.scan_div(scan_div)) lab_top_inst
    (
        .clk       (clk),
        .rst       (rst),
        .slow_clk  (slow_clk),
        .key       (key),
        .sw        (sw),
        .mic_value (mic_value),
        .mic_valid (mic_valid),
        .led       (led),
        .disp      (disp)
    );

    seg7_scanner seg7_scanner_inst
    (
        .clk      (clk),
        .rst      (rst),
        .disp     (disp),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    seg7_static_latch seg7_static_latch_inst
    (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .dp       (dp)
    );

endmodule

`default_nettype wire

// ==== bench/board_top_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module board_top_assert import board_pkg::*;
(
    input wire               clk,
    input wire               rst,
    input wire [3:0]         key,
    input wire [8:0]         sw,
    input wire [w_led-1:0]   led,
    input wire [6:0]         hex0,
    input wire [6:0]         hex1,
    input wire [6:0]         hex2,
    input wire [6:0]         hex3,
    input wire [w_digit-1:0] dp,
    input wire               mic_sck,
    input wire               mic_ws,
    input wire [w_digit-1:0] digit,     // Scanner select
    input wire               scan_step
);

    int fail_count = 0;  // Assertion failures so far

    //----------------------------------------------------------------------
    // Reset and counter
    //----------------------------------------------------------------------

    reset_outputs: assert property (@(posedge clk)
        rst && $past(rst) |-> hex0 == 7'h7f && hex1 == 7'h7f && hex2 == 7'h7f
            && hex3 == 7'h7f && dp == '0 && led == '0 && !mic_sck && !mic_ws
            && digit == 4'b0001)
        else
        begin
            fail_count++;
            $error("Outputs not at reset values");
        end

    led_step: assert property (@(posedge clk) disable iff (rst)
        led != $past(led) |-> (led == $past(led) + 14'd1) || $past(key[1]))
        else
        begin
            fail_count++;
            $error("led moved by other than one count");
        end

    led_pause: assert property (@(posedge clk) disable iff (rst)
        $past(sw[0]) && !$past(key[1]) |-> $stable(led))
        else
        begin
            fail_count++;
            $error("led changed while paused");
        end

    //----------------------------------------------------------------------
    // Scanner and sticky latch
    //----------------------------------------------------------------------

    digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(digit))
        else
        begin
            fail_count++;
            $error("Digit select not one-hot");
        end

    digit_rotate: assert property (@(posedge clk) disable iff (rst)
        scan_step |=> digit == {$past(digit[2:0]), $past(digit[3])})
        else
        begin
            fail_count++;
            $error("Digit select did not advance on scan step");
        end

    digit_hold: assert property (@(posedge clk) disable iff (rst)
        !scan_step |=> $stable(digit))
        else
        begin
            fail_count++;
            $error("Digit select moved without scan step");
        end

    hex0_sticky: assert property (@(posedge clk) disable iff (rst)
        !digit[0] |=> $stable(hex0))
        else
        begin
            fail_count++;
            $error("hex0 changed while not scanned");
        end

    hex1_sticky: assert property (@(posedge clk) disable iff (rst)
        !digit[1] |=> $stable(hex1))
        else
        begin
            fail_count++;
            $error("hex1 changed while not scanned");
        end

    hex2_sticky: assert property (@(posedge clk) disable iff (rst)
        !digit[2] |=> $stable(hex2))
        else
        begin
            fail_count++;
            $error("hex2 changed while not scanned");
        end

    hex3_sticky: assert property (@(posedge clk) disable iff (rst)
        !digit[3] |=> $stable(hex3))
        else
        begin
            fail_count++;
            $error("hex3 changed while not scanned");
        end

    dp_sticky: assert property (@(posedge clk) disable iff (rst)
        ((dp ^ $past(dp)) & ~$past(digit)) == '0)
        else
        begin
            fail_count++;
            $error("dp bit changed while its digit was not scanned");
        end

endmodule

bind board_top board_top_assert board_top_assert_inst
(
    .clk       (clk),
    .rst       (rst),
    .key       (key),
    .sw        (sw),
    .led       (led),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .dp        (dp),
    .mic_sck   (mic_sck),
    .mic_ws    (mic_ws),
    .digit     (digit),
    .scan_step (disp.scan_step)
);

`default_nettype wire

// ==== bench/tb_board_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_board_top;

    localparam int slow_half  = 25;    // clk cycles per slow_clk half period
    localparam int wait_limit = 3000;  // Longest display wait, covers two mic frames

    logic        clk;
    logic        rst;
    logic [3:0]  key;
    logic [8:0]  sw;
    logic        mic_sd = 1'b0;        // Owned by the mic model
    wire  [13:0] led;
    wire  [6:0]  hex0;
    wire  [6:0]  hex1;
    wire  [6:0]  hex2;
    wire  [6:0]  hex3;
    wire  [3:0]  dp;
    wire         mic_sck;
    wire         mic_ws;

    logic [23:0] mic_word;             // Word the mic model sends
    logic [5:0]  model_slot;           // Bit slot as the mic sees it
    logic        model_sck_d;
    logic        model_ws_d;
    int          bit_idx;

    integer      seed;
    logic [31:0] rnd;
    logic [13:0] led_prev;
    logic [15:0] count_seen;           // Expected counter value, one per observed step
    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    board_top
    #(
        .clk_mhz     (50),
        .slow_clk_hz (1_000_000),      // 25 cycle half period
        .mic_sck_div (2),
        .scan_div    (16)
    )
    board_top_inst
    (
        .clk     (clk),
        .rst     (rst),
        .key     (key),
        .sw      (sw),
        .mic_sd  (mic_sd),
        .led     (led),
        .hex0    (hex0),
        .hex1    (hex1),
        .hex2    (hex2),
        .hex3    (hex3),
        .dp      (dp),
        .mic_sck (mic_sck),
        .mic_ws  (mic_ws)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;             // 20 ns period

    //----------------------------------------------------------------------
    // I2S microphone model
    //----------------------------------------------------------------------

    always @(negedge clk)
    begin
        if (rst)
            model_slot = '0;
        else if (model_ws_d && !mic_ws)
            model_slot = '0;                 // Left channel starts
        else if (model_sck_d && !mic_sck)
            model_slot = model_slot + 6'd1;  // Next slot on falling sck

        // One-bit delay after ws, then MSB first
        bit_idx = 24 - int'(model_slot);
        if (!rst && !mic_ws && model_slot >= 6'd1 && model_slot <= 6'd24)
            mic_sd = mic_word[bit_idx];
        else
            mic_sd = 1'b0;

        model_sck_d = mic_sck;
        model_ws_d  = mic_ws;
    end

    //----------------------------------------------------------------------
    // Expected display
    //----------------------------------------------------------------------

    // Active-low HEX pattern, bit 0 is segment a
    function automatic logic [6:0] hex_pattern(input logic [3:0] n);
        logic [6:0] gfedcba;
        case (n)
            4'h0: gfedcba = 7'h3f;
            4'h1: gfedcba = 7'h06;
            4'h2: gfedcba = 7'h5b;
            4'h3: gfedcba = 7'h4f;
            4'h4: gfedcba = 7'h66;
            4'h5: gfedcba = 7'h6d;
            4'h6: gfedcba = 7'h7d;
            4'h7: gfedcba = 7'h07;
            4'h8: gfedcba = 7'h7f;
            4'h9: gfedcba = 7'h6f;
            4'ha: gfedcba = 7'h77;
            4'hb: gfedcba = 7'h7c;
            4'hc: gfedcba = 7'h39;
            4'hd: gfedcba = 7'h5e;
            4'he: gfedcba = 7'h79;
            default: gfedcba = 7'h71;
        endcase
        return ~gfedcba;
    endfunction

    // {hex3, hex2, hex1, hex0}, blanked digits dark
    function automatic logic [27:0] display_pattern(input logic [15:0] value,
                                                    input logic [3:0]  blank);
        logic [27:0] p;
        for (int i = 0; i < 4; i++)
            p[7*i +: 7] = blank[i] ? 7'h7f : hex_pattern(value[4*i +: 4]);
        return p;
    endfunction

    //----------------------------------------------------------------------
    // Helpers
    //----------------------------------------------------------------------

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0)
            $display("%s: passed", test_name);
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("FAILED %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic wait_led_change(input int limit);
        int n;
        n        = 0;
        led_prev = led;
        while (led === led_prev && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= limit)
        begin
            $display("%s: timed out waiting for led to change", test_name);
            test_errors++;
        end
    endtask

    task automatic wait_display(input logic [27:0] want_hex, input logic [3:0] want_dp,
                                input int limit);
        int n;
        n = 0;
        while (({hex3, hex2, hex1, hex0} !== want_hex || dp !== want_dp) && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (n >= limit)
        begin
            $display("%s: timed out waiting for the display to settle", test_name);
            test_errors++;
        end
        check_val("hex3..hex0", want_hex, {hex3, hex2, hex1, hex0});
        check_val("dp", want_dp, dp);
    endtask

    //----------------------------------------------------------------------
    // Test sequence
    //----------------------------------------------------------------------

    initial
    begin
        rst          = 1'b1;
        key          = '0;
        sw           = '0;
        mic_word     = '0;
        count_seen   = '0;
        seed         = 18763;
        tests_run    = 0;
        tests_failed = 0;

        start_test("reset_state");
        repeat (3) @(negedge clk);           // Three rising edges in reset
        check_val("hex3..hex0", 28'hfffffff, {hex3, hex2, hex1, hex0});
        check_val("dp", 4'b0000, dp);
        check_val("led", 14'd0, led);
        rst = 1'b0;
        @(negedge clk);
        check_val("hex3..hex0", 28'hfffffff, {hex3, hex2, hex1, hex0});
        check_val("led", 14'd0, led);
        close_test();

        start_test("counter_pacing");
        for (int i = 0; i < 3; i++)
        begin
            wait_led_change(4 * slow_half);
            check_val("led step", led_prev + 14'd1, led);
        end
        sw[0] = 1'b1;                        // Pause
        @(negedge clk);
        led_prev = led;
        repeat (8 * slow_half) @(negedge clk);
        check_val("led paused", led_prev, led);
        key[1] = 1'b1;                       // Clear pulse
        @(negedge clk);
        key[1] = 1'b0;
        check_val("led cleared", 14'd0, led);  // Cleared on the next clock
        count_seen = '0;
        close_test();

        start_test("mic_capture");
        rnd      = $random(seed);
        mic_word = rnd[23:0];
        key[0]   = 1'b1;                     // Show mic sample
        wait_display(display_pattern(mic_word[23:8], 4'b0000), 4'b0000, wait_limit);
        key[0] = 1'b0;
        close_test();

        start_test("counter_display");
        sw[0] = 1'b0;
        for (int i = 0; i < 3; i++)
        begin
            wait_led_change(4 * slow_half);
            count_seen = count_seen + 16'd1;
        end
        sw[0] = 1'b1;
        @(negedge clk);
        check_val("led", count_seen[13:0], led);
        wait_display(display_pattern(count_seen, 4'b0000), 4'b0000, wait_limit);
        close_test();

        start_test("dots_blanking");
        sw[4:1] = 4'b1010;
        sw[8:5] = 4'b0001;                   // Blank digit 0
        wait_display(display_pattern(count_seen, sw[8:5]), sw[4:1] & ~sw[8:5], wait_limit);
        sw[8:5] = 4'b1000;                   // Blank digit 3
        wait_display(display_pattern(count_seen, sw[8:5]), sw[4:1] & ~sw[8:5], wait_limit);
        close_test();

        // Bound assertions watch the latch while values keep moving
        start_test("sticky_hold");
        sw = '0;
        for (int i = 0; i < 8; i++)
        begin
            key[0] = i[0];
            wait_led_change(4 * slow_half);
            count_seen = count_seen + 16'd1;
        end
        key[0] = 1'b0;
        sw[0]  = 1'b1;
        @(negedge clk);
        check_val("led", count_seen[13:0], led);
        wait_display(display_pattern(count_seen, 4'b0000), 4'b0000, wait_limit);
        close_test();

        $display("Tests run: %0d, passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_run, tests_run - tests_failed, tests_failed,
                 board_top_inst.board_top_assert_inst.fail_count);
        if (tests_failed == 0 && board_top_inst.board_top_assert_inst.fail_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
rtl/board_pkg.sv
rtl/display_if.sv
rtl/slow_clk_gen.sv
rtl/i2s_mic_receiver.sv
rtl/seg7_scanner.sv
rtl/seg7_static_latch.sv
rtl/lab_top.sv
rtl/board_top.sv
bench/board_top_assert.sv
bench/tb_board_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top \
    --Mdir "$build_dir" \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/Vtb_board_top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1
